/* build.f */
logic/dma_pkg.sv
logic/latch_ctrl_if.sv
logic/fill_sm.sv
logic/fifo_counter.sv
logic/fifo_datapath.sv
logic/dma_fill_top.sv
test/dma_fill_sva.sv
test/tb_dma_fill.sv

/* logic/dma_fill_top.sv */
// Top level of the memory to FIFO DMA fill path with the FSM, counter and datapath
`timescale 1ns/1ps

module dma_fill_top #(
    parameter int FIFO_DEPTH = dma_pkg::DEPTH_DEF   // Number of FIFO entries, a power of two
) (
    input  logic           CLK90,                   // Bus clock shifted by 90 degrees
    input  logic           nRESET,                  // Asynchronous reset, active low
    input  logic           dma_ena,                 // DMA is turned on
    input  logic           scsi_req,                // SCSI side asks for more data
    input  logic           bus_grant,               // Arbiter grants the bus
    input  logic           cycle_done,              // Previous bus cycle has ended
    input  logic           sterm,                   // Synchronous termination
    input  logic [1:0]     dsack,                   // Asynchronous termination per port half
    input  dma_pkg::data_t cpu_data,                // Read data from the CPU bus
    input  logic           scsi_pop,                // SCSI side takes one entry
    output logic           bus_request,             // Bus request to the arbiter
    output logic           bus_grant_ack,           // Bus mastership held
    output logic           addr_strobe,             // Address strobe
    output logic           data_strobe,             // Data strobe
    output logic           size16,                  // Word sized re-read
    output dma_pkg::data_t scsi_data,               // Oldest FIFO entry
    output logic           fifo_full,               // FIFO has no room left
    output logic           fifo_empty               // FIFO has nothing to give
);

    latch_ctrl_if lc ();                            // FSM to datapath control bundle

    fill_sm u_fill_sm (
        .CLK90         (CLK90),
        .nRESET        (nRESET),
        .dma_ena       (dma_ena),
        .scsi_req      (scsi_req),
        .bus_grant     (bus_grant),
        .cycle_done    (cycle_done),
        .sterm         (sterm),
        .dsack         (dsack),
        .full          (fifo_full),
        .empty         (fifo_empty),
        .bus_request   (bus_request),
        .bus_grant_ack (bus_grant_ack),
        .addr_strobe   (addr_strobe),
        .data_strobe   (data_strobe),
        .size16        (size16),
        .lc            (lc.ctrl)
    );

    fifo_counter #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_counter (
        .CLK90    (CLK90),
        .nRESET   (nRESET),
        .push     (lc.push),                        // Every FIFO write counts up
        .scsi_pop (scsi_pop),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

    fifo_datapath #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_datapath (
        .CLK90     (CLK90),
        .nRESET    (nRESET),
        .cpu_data  (cpu_data),
        .scsi_pop  (scsi_pop),
        .lc        (lc.path),
        .scsi_data (scsi_data)
    );

endmodule

/* logic/dma_pkg.sv */
// Shared widths, FIFO depth default, fill FSM state type and bus cycle termination codes
package dma_pkg;

    localparam int DATA_W    = 32;                  // Width of the CPU data bus and of one FIFO entry
    localparam int HALF_W    = 16;                  // Width of one half-word
    localparam int DEPTH_DEF = 8;                   // Default number of FIFO entries

    typedef logic [DATA_W-1:0] data_t;             // One longword
    typedef logic [HALF_W-1:0] half_t;             // One half-word

    // States of the fill FSM, from bus request through release
    typedef enum logic [3:0] {
        idle       = 4'd0,                          // Waiting for DMA enable, SCSI request and an empty FIFO
        bus_wait   = 4'd1,                          // Bus requested and waiting for grant and end of the last cycle
        start      = 4'd2,                          // Address phase of an aligned longword read
        cycle      = 4'd3,                          // Data phase of the longword read until termination
        half_start = 4'd4,                          // Address phase of the second half-word read
        half_cycle = 4'd5,                          // Data phase of the second half-word read
        half_wait  = 4'd6,                          // Gap that lets the 16-bit port negate its acknowledge
        advance    = 4'd7,                          // Entry written so check room in the FIFO
        letgo      = 4'd8                           // Last cycle holding the bus
    } fill_state_t;

    // How the current bus cycle ended in this clock
    typedef enum logic [1:0] {
        none      = 2'd0,                           // Cycle still running
        full_port = 2'd1,                           // STERM or both DSACK bits mean a 32-bit port
        half_port = 2'd2                            // Upper DSACK bit alone means a 16-bit port
    } term_t;

endpackage

/* logic/fifo_counter.sv */
// FIFO occupancy counter with full and empty flags
`timescale 1ns/1ps

module fifo_counter #(
    parameter int FIFO_DEPTH = dma_pkg::DEPTH_DEF   // Number of FIFO entries, a power of two
) (
    input  logic CLK90,                             // Bus clock shifted by 90 degrees
    input  logic nRESET,                            // Asynchronous reset, active low
    input  logic push,                              // One longword written by the fill FSM
    input  logic scsi_pop,                          // One longword taken by the SCSI side
    output logic full,                              // Count has reached FIFO_DEPTH
    output logic empty                              // Count is zero
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;  // One extra bit so FIFO_DEPTH fits

    logic [CNT_W-1:0] count;                        // Entries currently held
    logic             dec;                          // Pop that really removes an entry

    assign dec   = scsi_pop & ~empty;               // Pops on an empty FIFO are dropped
    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            count <= '0;
        end else begin
            case ({push, dec})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Push and pop together cancel out
            endcase
        end
    end

endmodule

/* logic/fifo_datapath.sv */
// Half-word input latches with upper to lower bridging and circular FIFO storage
`timescale 1ns/1ps

module fifo_datapath #(
    parameter int FIFO_DEPTH = dma_pkg::DEPTH_DEF   // Number of FIFO entries, a power of two
) (
    input  logic           CLK90,                   // Bus clock shifted by 90 degrees
    input  logic           nRESET,                  // Asynchronous reset, active low
    input  dma_pkg::data_t cpu_data,                // Read data from the CPU bus
    input  logic           scsi_pop,                // SCSI side takes the current entry
    latch_ctrl_if.path     lc,                      // Latch and write controls from the FSM
    output dma_pkg::data_t scsi_data                // Entry at the read pointer
);
    import dma_pkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH);      // Bits needed to index one entry

    half_t          high_in;                        // Upper lanes after the input enable
    half_t          low_in;                         // Source for the low latch after the bridge
    half_t          high_nxt;                       // High latch as it is after this edge
    half_t          low_nxt;                        // Low latch as it is after this edge
    half_t          high_q;                         // High half-word latch
    half_t          low_q;                          // Low half-word latch
    data_t          mem [FIFO_DEPTH];               // FIFO storage
    logic [IDX_W:0] wr_ptr;                         // Write pointer with wrap bit
    logic [IDX_W:0] rd_ptr;                         // Read pointer with wrap bit
    logic           pop_ok;                         // Pop that moves the read pointer

    // Disabled lanes read as zero
    assign high_in = lc.enable_high ? cpu_data[DATA_W-1:HALF_W] : '0;

    // On a 16-bit port the second half-word arrives on the upper lanes
    always_comb begin
        if (lc.bridge_in) begin
            low_in = high_in;
        end else if (lc.enable_low) begin
            low_in = cpu_data[HALF_W-1:0];
        end else begin
            low_in = '0;
        end
    end

    assign high_nxt = lc.latch_high ? high_in : high_q;
    assign low_nxt  = lc.latch_low ? low_in : low_q;

    always_ff @(posedge CLK90) begin
        high_q <= high_nxt;
        low_q  <= low_nxt;
        if (lc.push) begin
            mem[wr_ptr[IDX_W-1:0]] <= {high_nxt, low_nxt};  // Includes data caught on this edge
        end
    end

    // Equal pointers mean no entry so the read pointer stays in step with the counter
    assign pop_ok = scsi_pop & (rd_ptr != wr_ptr);

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (lc.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign scsi_data = mem[rd_ptr[IDX_W-1:0]];      // Shows the oldest entry at all times

endmodule

/* logic/fill_sm.sv */
// Fill FSM that takes the bus and reads longwords from memory into the FIFO
`timescale 1ns/1ps

module fill_sm (
    input  logic        CLK90,                      // Bus clock shifted by 90 degrees
    input  logic        nRESET,                     // Asynchronous reset, active low
    input  logic        dma_ena,                    // DMA is turned on
    input  logic        scsi_req,                   // SCSI side asks for more data
    input  logic        bus_grant,                  // Arbiter grants the bus
    input  logic        cycle_done,                 // Previous bus owner has ended its cycle
    input  logic        sterm,                      // Synchronous termination from a 32-bit port
    input  logic [1:0]  dsack,                      // Asynchronous termination per port half
    input  logic        full,                       // FIFO holds FIFO_DEPTH entries
    input  logic        empty,                      // FIFO holds no entry
    output logic        bus_request,                // Request for bus mastership
    output logic        bus_grant_ack,              // We own the bus
    output logic        addr_strobe,                // Address strobe of the read cycle
    output logic        data_strobe,                // Data strobe of the read cycle
    output logic        size16,                     // Word sized transfer for the re-read
    latch_ctrl_if.ctrl  lc                          // Controls for the input latches and FIFO write
);
    import dma_pkg::*;

    fill_state_t state;                             // Current FSM state
    fill_state_t state_nxt;                         // State after the next edge
    term_t       term;                              // Termination seen in this clock
    logic        bus_free;                          // Grant present and the bus is idle

    assign bus_free = bus_grant & cycle_done;       // Both must hold in the same clock

    // STERM wins over DSACK and the lower DSACK bit alone is not a supported port
    always_comb begin
        if (sterm || dsack == 2'b11) begin
            term = full_port;
        end else if (dsack == 2'b10) begin
            term = half_port;
        end else begin
            term = none;
        end
    end

    always_comb begin
        state_nxt = state;                          // Stay unless a branch below moves on
        case (state)
            idle: begin
                if (dma_ena && scsi_req && empty) begin
                    state_nxt = bus_wait;           // Only an empty FIFO starts a fill
                end
            end
            bus_wait: begin
                if (bus_free) begin
                    state_nxt = start;
                end
            end
            start:      state_nxt = cycle;          // Address phase always takes one clock
            cycle: begin
                if (term == full_port) begin
                    state_nxt = advance;            // Whole longword arrived
                end else if (term == half_port) begin
                    state_nxt = half_wait;          // Only the upper half came back
                end
            end
            half_wait:  state_nxt = half_start;
            half_start: state_nxt = half_cycle;
            half_cycle: begin
                if (term != none) begin
                    state_nxt = advance;            // Second half-word is in
                end
            end
            advance:    state_nxt = full ? letgo : start;
            letgo:      state_nxt = idle;
            default:    state_nxt = idle;
        endcase
    end

    // Outputs depend on the state and on termination in the same clock
    always_comb begin
        bus_request    = (state != idle);           // Held from bus_wait through letgo
        bus_grant_ack  = 1'b0;
        addr_strobe    = 1'b0;
        data_strobe    = 1'b0;
        size16         = 1'b0;
        lc.latch_high  = 1'b0;
        lc.latch_low   = 1'b0;
        lc.enable_high = 1'b0;
        lc.enable_low  = 1'b0;
        lc.bridge_in   = 1'b0;
        lc.push        = 1'b0;
        case (state)
            bus_wait: begin
                bus_grant_ack = bus_free;           // Acknowledge in the clock the bus is taken
            end
            start: begin
                bus_grant_ack = 1'b1;
                addr_strobe   = 1'b1;
            end
            cycle: begin
                bus_grant_ack  = 1'b1;
                lc.enable_high = 1'b1;              // Both lanes feed the latches
                lc.enable_low  = 1'b1;
                if (term == none) begin
                    addr_strobe = 1'b1;
                    data_strobe = 1'b1;
                end else begin
                    lc.latch_high = 1'b1;           // Upper lanes are valid for either port
                end
                if (term == full_port) begin
                    lc.latch_low = 1'b1;            // Lower lanes only count on a 32-bit port
                    lc.push      = 1'b1;
                end
            end
            half_wait: begin
                bus_grant_ack = 1'b1;               // Strobes stay off for one clock
            end
            half_start: begin
                bus_grant_ack = 1'b1;
                addr_strobe   = 1'b1;
                size16        = 1'b1;
            end
            half_cycle: begin
                bus_grant_ack  = 1'b1;
                lc.enable_high = 1'b1;
                lc.bridge_in   = 1'b1;              // Second half-word comes back on the upper lanes
                if (term == none) begin
                    addr_strobe = 1'b1;
                    data_strobe = 1'b1;
                    size16      = 1'b1;
                end else begin
                    lc.latch_low = 1'b1;
                    lc.push      = 1'b1;            // High latch already holds the first half
                end
            end
            advance: begin
                bus_grant_ack = 1'b1;
            end
            letgo: begin
                bus_grant_ack = 1'b1;               // Bus goes back after this clock
            end
            default: begin
                bus_grant_ack = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* logic/latch_ctrl_if.sv */
// Input latch control bundle between the fill FSM and the FIFO datapath
`timescale 1ns/1ps

interface latch_ctrl_if;

    logic latch_high;                               // Load the high half-word latch on this edge
    logic latch_low;                                // Load the low half-word latch on this edge
    logic enable_high;                              // Let the upper data lanes into the latches
    logic enable_low;                               // Let the lower data lanes into the low latch
    logic bridge_in;                                // Steer the upper lanes into the low latch
    logic push;                                     // Write the latch pair into the FIFO

    // The FSM side drives every control
    modport ctrl (
        output latch_high,
        output latch_low,
        output enable_high,
        output enable_low,
        output bridge_in,
        output push
    );

    // The datapath only consumes them
    modport path (
        input latch_high,
        input latch_low,
        input enable_high,
        input enable_low,
        input bridge_in,
        input push
    );

endinterface

/* run_sim.sh */
#!/bin/sh
# Compile the DMA fill testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_dma_fill -f build.f -o sim_dma_fill
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dma_fill +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** PASSED ***" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* test/dma_fill_sva.sv */
// Bound concurrent checks on fill FSM bus ownership, strobes and FIFO writes
`timescale 1ns/1ps

module dma_fill_sva (
    input logic CLK90,                              // Bus clock
    input logic nRESET,                             // Checks are off during reset
    input logic bus_grant,                          // Grant from the arbiter
    input logic bus_grant_ack,                      // Bus ownership
    input logic addr_strobe,                        // Address strobe
    input logic data_strobe,                        // Data strobe
    input logic size16,                             // Word sized re-read
    input logic push,                               // FIFO write from the FSM
    input logic full                                // FIFO has no room
);

    int fail_cnt = 0;                               // Number of failed checks, read at the end

    a_strobe_owned: assert property (@(posedge CLK90) disable iff (!nRESET)
        (addr_strobe || data_strobe || size16) |-> bus_grant_ack)
        else begin fail_cnt++; $error("Strobe or size16 active without bus ownership"); end

    a_no_push_full: assert property (@(posedge CLK90) disable iff (!nRESET) push |-> !full)
        else begin fail_cnt++; $error("FIFO write while the FIFO is full"); end

    a_ack_granted: assert property (@(posedge CLK90) disable iff (!nRESET)
        $rose(bus_grant_ack) |-> bus_grant)
        else begin fail_cnt++; $error("Bus ownership taken without a grant"); end

endmodule

bind fill_sm dma_fill_sva u_sva (.CLK90(CLK90), .nRESET(nRESET), .bus_grant(bus_grant),
    .bus_grant_ack(bus_grant_ack), .addr_strobe(addr_strobe), .data_strobe(data_strobe),
    .size16(size16), .push(lc.push), .full(full));

/* test/tb_dma_fill.sv */
// Testbench with clock, reset, LFSR, arbiter and bus slave models, SCSI drain and FIFO model
`timescale 1ns/1ps

module tb_dma_fill;
    import dma_pkg::*;

    localparam int FIFO_DEPTH = DEPTH_DEF;          // Same depth as the DUT default

    logic        CLK90;
    logic        nRESET = 1'b0;
    logic        dma_ena = 1'b0;
    logic        scsi_req = 1'b0;
    logic        bus_grant = 1'b0;
    logic        cycle_done = 1'b0;
    logic        sterm = 1'b0;
    logic [1:0]  dsack = 2'b00;
    data_t       cpu_data = '0;
    logic        scsi_pop = 1'b0;
    logic        bus_request;
    logic        bus_grant_ack;
    logic        addr_strobe;
    logic        data_strobe;
    logic        size16;
    logic        fifo_full;
    logic        fifo_empty;
    data_t       scsi_data;

    logic [31:0] lfsr = 32'd56;                     // Galois LFSR state
    data_t       ref_q[$];                          // Longwords expected out of the FIFO in order
    half_t       first_half = '0;                   // Upper half of the first 16-bit read
    int          model_count = 0;                   // Occupancy as the model sees it
    int          release_cnt = 0;                   // Negedges left until bus_grant_ack must drop
    int          waits_left = 0;                    // Wait states left in the running bus cycle
    int          grant_wait = 0;                    // Arbiter delay before the grant
    int          port_mode = 0;                     // 0 sterm, 1 both dsack bits, 2 upper dsack only
    int          max_wait = 0;                      // Nonzero allows random wait states
    int          pop_mode = 0;                      // 0 none, 1 sparse random pops, 2 pop always
    int          data_errs = 0;
    int          flag_errs = 0;
    int          other_errs = 0;
    bit          want_ena = 1'b0;                   // Values copied to the DUT on the next negedge
    bit          want_req = 1'b0;
    bit          in_cycle = 1'b0;                   // A data phase is being served
    bit          term_active = 1'b0;                // Termination was driven on the last negedge
    bit          seen_size16 = 1'b0;
    bit          armed = 1'b0;                      // Idle FSM may leave idle on the coming edge
    bit          prev_req = 1'b0;
    bit          prev_ack = 1'b0;
    bit          prev_as = 1'b0;                    // Address strobe one clock earlier
    bit          timed_out = 1'b0;

    dma_fill_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

    initial begin
        CLK90 = 1'b0;
        forever #20 CLK90 = ~CLK90;                 // 40 ns period
    end

    // One LFSR step for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errs++;
        timed_out = 1'b1;                           // Later scenarios are skipped
        $display("Timeout while waiting for %s", what);
    endtask

    // Arbiter grants after a random delay and toggles the end of the foreign cycle
    task automatic arbitrate();
        if (!bus_request) begin
            bus_grant = 1'b0;
            grant_wait = int'(take_bits(2));
        end else if (grant_wait > 0) begin
            grant_wait--;
        end else begin
            bus_grant = 1'b1;
        end
        cycle_done = (take_bits(1) != 0);
    endtask

    // Bus slave answers each data phase and records what the FIFO has to hold
    task automatic serve_bus(output bit push_now);
        data_t word;
        push_now = 1'b0;
        if (term_active) begin
            sterm = 1'b0;                           // Termination lasts one clock
            dsack = 2'b00;
            term_active = 1'b0;
        end else if (data_strobe) begin
            word = take_bits(32);
            cpu_data = word;                        // Lanes carry noise during wait states
            if (!in_cycle) begin
                in_cycle = 1'b1;
                waits_left = (max_wait != 0) ? int'(take_bits(2)) : 0;
            end
            if (waits_left > 0) begin
                waits_left--;
            end else begin
                in_cycle = 1'b0;
                term_active = 1'b1;
                if (size16) begin
                    dsack = 2'b10;                  // Re-read ends the entry
                    ref_q.push_back({first_half, word[31:16]});
                    push_now = 1'b1;
                end else if (port_mode == 2) begin
                    dsack = 2'b10;
                    first_half = word[31:16];
                end else begin
                    if (port_mode == 1) dsack = 2'b11;
                    else sterm = 1'b1;
                    ref_q.push_back(word);
                    push_now = 1'b1;
                end
            end
        end
    endtask

    // Outputs settled after the rising edge are checked, then inputs and the model move on
    always @(negedge CLK90) begin : drive_and_model
        bit push_now;
        bit pop_eff;
        if (nRESET) begin
            check_flag("fifo_empty", fifo_empty, model_count == 0);
            check_flag("fifo_full", fifo_full, model_count == FIFO_DEPTH);
            if (!prev_req) check_flag("bus_request", bus_request, armed);
            if (bus_grant_ack && !prev_ack) begin
                check_flag("bus_grant & cycle_done", bus_grant && cycle_done, 1'b1);
            end
            if (prev_ack && release_cnt == 0) begin
                check_flag("bus_grant_ack", bus_grant_ack, 1'b1);  // Bus kept until the FIFO is full
            end
            if (release_cnt > 0) begin
                release_cnt--;
                check_flag("bus_grant_ack", bus_grant_ack, release_cnt != 0);
            end
            if (data_strobe && size16) seen_size16 = 1'b1;
            if (data_strobe) begin
                check_flag("addr_strobe", addr_strobe, 1'b1);  // Address held through the data phase
                if (!in_cycle) check_flag("addr_strobe before data_strobe", prev_as, 1'b1);
            end
            if (addr_strobe && !prev_as) begin
                check_flag("data_strobe", data_strobe, 1'b0);  // Address phase comes alone
            end
            prev_req = bus_request;
            prev_ack = bus_grant_ack;
            prev_as = addr_strobe;
            dma_ena = want_ena;
            scsi_req = want_req;
            arbitrate();
            scsi_pop = (pop_mode == 2) || (pop_mode == 1 && take_bits(4) == 0);
            serve_bus(push_now);
            armed = dma_ena && scsi_req && (model_count == 0);
            pop_eff = scsi_pop && (model_count > 0);
            if (pop_eff) check_data("scsi_data", scsi_data, ref_q.pop_front());
            model_count = model_count + int'(push_now) - int'(pop_eff);
            if (push_now && model_count == FIFO_DEPTH) release_cnt = 3;
        end
    end

    task automatic fill_and_drain(input int mode, input int waits, input int pops);
        int i;
        if (timed_out) return;
        port_mode = mode;
        max_wait = waits;
        pop_mode = pops;
        seen_size16 = 1'b0;
        want_ena = 1'b1;
        want_req = 1'b1;
        for (i = 0; i < 100 && !bus_request; i++) @(posedge CLK90);
        if (!bus_request) begin
            report_timeout("bus_request at the start of a fill");
            return;
        end
        for (i = 0; i < 4000 && bus_request; i++) @(posedge CLK90);
        pop_mode = 0;
        if (bus_request) begin
            report_timeout("the bus release after a fill");
            return;
        end
        repeat (6) @(posedge CLK90);               // FIFO holds data so no request may follow
        want_req = 1'b0;
        pop_mode = 2;
        for (i = 0; i < 100 && model_count != 0; i++) @(posedge CLK90);
        pop_mode = 0;
        if (model_count != 0) begin
            report_timeout("the FIFO to drain");
            return;
        end
        check_flag("size16", seen_size16, mode == 2);  // Re-reads only happen on a 16-bit port
        if (ref_q.size() != 0) begin
            other_errs++;
            $display("Reference queue still holds %0d entries after draining", ref_q.size());
        end
        repeat (2) @(posedge CLK90);
    endtask

    task automatic finish_run();
        int sva_errs;
        sva_errs = DUT.u_fill_sm.u_sva.fail_cnt;
        $display("Errors: data %0d, flag %0d, other %0d, assertion %0d",
                 data_errs, flag_errs, other_errs, sva_errs);
        if (data_errs + flag_errs + other_errs + sva_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        repeat (4) @(posedge CLK90);
        @(negedge CLK90);
        nRESET <= 1'b1;
        @(posedge CLK90);
        want_req = 1'b1;                            // Request without DMA enable stays idle
        repeat (10) @(posedge CLK90);
        want_ena = 1'b1;                            // Enable without SCSI request stays idle
        want_req = 1'b0;
        repeat (10) @(posedge CLK90);
        fill_and_drain(0, 0, 0);                    // 32-bit port with sterm and no waits
        fill_and_drain(1, 1, 0);                    // 32-bit port with dsack and wait states
        fill_and_drain(2, 1, 0);                    // 16-bit port with re-read
        fill_and_drain(1, 1, 1);                    // Pops while filling
        fill_and_drain(2, 1, 1);
        finish_run();
    end

endmodule
